//--- source/vshift_defs.svh
`ifndef VSHIFT_DEFS_SVH
`define VSHIFT_DEFS_SVH

// vector register geometry
`define VLEN            128
`define VLENB           (`VLEN/8)

// scalar register width
`define XLEN            32

`define ROB_DEPTH_WIDTH 4
`define UOP_INDEX_WIDTH 3

// one slice of the datapath
`define LANE_WIDTH      32
`define NUM_LANES       (`VLEN/`LANE_WIDTH)

`endif

//--- source/vshift_pkg.sv
`include "vshift_defs.svh"

package vshift_pkg;

  // rvv funct6 encodings of the shift group
  typedef enum logic [5:0] {
    VSLL    = 6'b100101,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001,
    VSSRL   = 6'b101010,
    VSSRA   = 6'b101011,
    VNSRL   = 6'b101100,
    VNSRA   = 6'b101101,
    VNCLIPU = 6'b101110,
    VNCLIP  = 6'b101111
  } vshift_funct_e;

  // funct3 encodings
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } operand_src_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // fixed-point rounding mode
  typedef enum logic [1:0] {
    RNU = 2'b00,
    RNE = 2'b01,
    RDN = 2'b10,
    ROD = 2'b11
  } vxrm_e;

  typedef enum logic [1:0] {
    SHIFT_SLL,
    SHIFT_SRL,
    SHIFT_SRA
  } shift_op_e;

  typedef enum logic [2:0] {
    RES_PLAIN,
    RES_SCALED,
    RES_NARROW,
    RES_CLIPU,
    RES_CLIP
  } result_mode_e;

  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    vshift_funct_e               funct;
    operand_src_e                src;
    vxrm_e                       vxrm;
    eew_e                        vs2_eew;
    logic [`VLEN-1:0]            vs1_data;
    logic                        vs1_data_valid;
    logic [`VLEN-1:0]            vs2_data;
    logic                        vs2_data_valid;
    logic [`XLEN-1:0]            rs1_data;
    logic                        rs1_data_valid;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
  } shift_uop_t;

  typedef struct packed {
    shift_op_e    op;
    result_mode_e mode;
    eew_e         eew;
    vxrm_e        vxrm;
    logic         upper_half;
  } shift_ctrl_t;

  // carry-outs are only meaningful at the matching eew
  typedef struct packed {
    logic [`LANE_WIDTH-1:0] product;
    logic [`LANE_WIDTH-1:0] rounded;
    logic [1:0]             cout16;
    logic                   cout32;
  } lane_out_t;

  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [`VLEN-1:0]            w_data;
    logic [`VLENB-1:0]           vsaturate;
  } shift_result_t;

endpackage

//--- source/vshift_operand_prep.sv
`timescale 1ns/1ps
`include "vshift_defs.svh"

module vshift_operand_prep (
  input  logic                    uop_valid,
  input  vshift_pkg::shift_uop_t  uop,
  output logic                    legal,
  output vshift_pkg::shift_ctrl_t ctrl,
  output logic [`VLEN-1:0]        operands,
  output logic [`VLEN-1:0]        amounts
);
  import vshift_pkg::*;

  logic known;
  logic is_narrow;
  logic vector_src;
  logic src_ok;
  logic wide_eew;

  // opcode decode
  always_comb begin
    ctrl.op         = SHIFT_SLL;
    ctrl.mode       = RES_PLAIN;
    ctrl.eew        = uop.vs2_eew;
    ctrl.vxrm       = uop.vxrm;
    ctrl.upper_half = uop.uop_index[0];
    known           = 1'b1;
    is_narrow       = 1'b0;
    case (uop.funct)
      VSLL:    ctrl.op = SHIFT_SLL;
      VSRL:    ctrl.op = SHIFT_SRL;
      VSRA:    ctrl.op = SHIFT_SRA;
      VSSRL: begin
        ctrl.op   = SHIFT_SRL;
        ctrl.mode = RES_SCALED;
      end
      VSSRA: begin
        ctrl.op   = SHIFT_SRA;
        ctrl.mode = RES_SCALED;
      end
      VNSRL: begin
        ctrl.op   = SHIFT_SRL;
        ctrl.mode = RES_NARROW;
        is_narrow = 1'b1;
      end
      VNSRA: begin
        ctrl.op   = SHIFT_SRA;
        ctrl.mode = RES_NARROW;
        is_narrow = 1'b1;
      end
      VNCLIPU: begin
        ctrl.op   = SHIFT_SRL;
        ctrl.mode = RES_CLIPU;
        is_narrow = 1'b1;
      end
      VNCLIP: begin
        ctrl.op   = SHIFT_SRA;
        ctrl.mode = RES_CLIP;
        is_narrow = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // immediate form behaves like the scalar form
  assign vector_src = (uop.src == OPIVV);
  assign src_ok     = uop.vs2_data_valid &
                      (vector_src ? uop.vs1_data_valid : uop.rs1_data_valid);
  assign wide_eew   = (uop.vs2_eew == EEW16) | (uop.vs2_eew == EEW32);
  assign legal      = uop_valid & known & src_ok & (~is_narrow | wide_eew);

  assign operands = uop.vs2_data;

  // per-element shift amount, placed at the element's own position
  always_comb begin
    logic [4:0] raw;
    int         half_off;
    half_off = uop.uop_index[0] ? `VLEN/2 : 0;
    raw      = '0;
    amounts  = '0;
    case (uop.vs2_eew)
      EEW8: begin
        for (int i = 0; i < `VLENB; i++) begin
          raw = vector_src ? uop.vs1_data[8*i +: 5] : uop.rs1_data[4:0];
          amounts[8*i +: 8] = {5'b0, raw[2:0]};
        end
      end
      EEW16: begin
        for (int i = 0; i < `VLEN/16; i++) begin
          if (!vector_src)
            raw = uop.rs1_data[4:0];
          else if (is_narrow)
            raw = uop.vs1_data[half_off + 8*i +: 5];
          else
            raw = uop.vs1_data[16*i +: 5];
          amounts[16*i +: 16] = {12'b0, raw[3:0]};
        end
      end
      default: begin
        for (int i = 0; i < `VLEN/32; i++) begin
          if (!vector_src)
            raw = uop.rs1_data[4:0];
          else if (is_narrow)
            raw = uop.vs1_data[half_off + 16*i +: 5];
          else
            raw = uop.vs1_data[32*i +: 5];
          amounts[32*i +: 32] = {27'b0, raw};
        end
      end
    endcase
  end

endmodule

//--- source/vshift_lane.sv
`timescale 1ns/1ps
`include "vshift_defs.svh"

module vshift_lane (
  input  vshift_pkg::shift_ctrl_t ctrl,
  input  logic [`LANE_WIDTH-1:0]  operand,
  input  logic [`LANE_WIDTH-1:0]  amount,
  output vshift_pkg::lane_out_t   lane
);
  import vshift_pkg::*;

  logic             sra;
  logic [3:0][7:0]  prod8;
  logic [3:0][7:0]  rnd8;
  logic [1:0][15:0] prod16;
  logic [1:0][15:0] rnd16;
  logic [1:0]       cout16;
  logic [31:0]      prod32;
  logic [31:0]      rnd32;
  logic             cout32;

  // upper word is the shifted element, lower word the bits shifted out
  function automatic logic [63:0] f_shift(input shift_op_e op, input logic [31:0] src,
                                          input logic [4:0] amt);
    logic signed [64:0] full;
    full = {(op == SHIFT_SRA) & src[31], src, 32'b0};
    if (op == SHIFT_SLL)
      full = full << amt;
    else
      full = full >>> amt;
    return full[63:0];
  endfunction

  // rounded value plus carry-out in bit 32
  function automatic logic [32:0] f_round(input vxrm_e rm, input logic sgn,
                                          input logic [63:0] sh);
    logic        inc;
    logic [31:0] val;
    logic [31:0] rb;
    val = sh[63:32];
    rb  = sh[31:0];
    case (rm)
      RNU:     inc = rb[31];
      RNE:     inc = rb[31] & ((|rb[30:0]) | val[0]);
      RDN:     inc = 1'b0;
      default: inc = ~val[0] & (|rb);
    endcase
    return {sgn & val[31], val} + {32'b0, inc};
  endfunction

  assign sra = (ctrl.op == SHIFT_SRA);

  for (genvar b = 0; b < 4; b++) begin : g_byte
    logic [31:0] src;
    logic [63:0] sh;
    logic [32:0] rs;
    assign src      = {{24{sra & operand[8*b+7]}}, operand[8*b +: 8]};
    assign sh       = f_shift(ctrl.op, src, {2'b0, amount[8*b +: 3]});
    assign rs       = f_round(ctrl.vxrm, sra, sh);
    assign prod8[b] = sh[39:32];
    assign rnd8[b]  = rs[7:0];
  end

  for (genvar h = 0; h < 2; h++) begin : g_half
    logic [31:0] src;
    logic [63:0] sh;
    logic [32:0] rs;
    assign src       = {{16{sra & operand[16*h+15]}}, operand[16*h +: 16]};
    assign sh        = f_shift(ctrl.op, src, {1'b0, amount[16*h +: 4]});
    assign rs        = f_round(ctrl.vxrm, sra, sh);
    assign prod16[h] = sh[47:32];
    assign rnd16[h]  = rs[15:0];
    // 17-bit sum top bit, sign of the rounded value for sra
    assign cout16[h] = rs[16];
  end

  // full word element
  logic [63:0] sh32;
  logic [32:0] rs32;
  assign sh32   = f_shift(ctrl.op, operand, amount[4:0]);
  assign rs32   = f_round(ctrl.vxrm, sra, sh32);
  assign prod32 = sh32[63:32];
  assign rnd32  = rs32[31:0];
  assign cout32 = rs32[32];

  always_comb begin
    lane.cout16 = cout16;
    lane.cout32 = cout32;
    case (ctrl.eew)
      EEW8: begin
        lane.product = prod8;
        lane.rounded = rnd8;
      end
      EEW16: begin
        lane.product = prod16;
        lane.rounded = rnd16;
      end
      default: begin
        lane.product = prod32;
        lane.rounded = rnd32;
      end
    endcase
  end

endmodule

//--- source/vshift_result_pack.sv
`timescale 1ns/1ps
`include "vshift_defs.svh"

module vshift_result_pack (
  input  vshift_pkg::shift_ctrl_t                  ctrl,
  input  vshift_pkg::lane_out_t [`NUM_LANES-1:0]   lanes,
  output logic [`VLEN-1:0]                         w_data,
  output logic [`VLENB-1:0]                        vsaturate
);
  import vshift_pkg::*;

  logic                        sgn;
  logic                        eew16;
  logic [`NUM_LANES-1:0][15:0] narrow;
  logic [`NUM_LANES-1:0][15:0] clipped;
  logic [`NUM_LANES-1:0][1:0]  sat;

  // saturate an extended value to dw bits, returns {saturated, data}
  function automatic logic [16:0] f_clip(input logic is_signed, input logic [32:0] val,
                                         input int dw);
    logic signed [33:0] v;
    logic signed [33:0] max_v;
    logic signed [33:0] min_v;
    v     = {is_signed & val[32], val};
    max_v = is_signed ? (34'sd1 <<< (dw - 1)) - 34'sd1 : (34'sd1 <<< dw) - 34'sd1;
    min_v = is_signed ? -(34'sd1 <<< (dw - 1)) : 34'sd0;
    if (v > max_v)
      return {1'b1, max_v[15:0]};
    else if (v < min_v)
      return {1'b1, min_v[15:0]};
    else
      return {1'b0, val[15:0]};
  endfunction

  assign sgn   = (ctrl.mode == RES_CLIP);
  assign eew16 = (ctrl.eew == EEW16);

  // each lane yields 16 narrowed bits
  for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
    logic [16:0] clip_lo;
    logic [16:0] clip_hi;
    logic [16:0] clip_w;
    assign clip_lo = f_clip(sgn, {{16{sgn & lanes[l].cout16[0]}}, lanes[l].cout16[0],
                                  lanes[l].rounded[15:0]}, 8);
    assign clip_hi = f_clip(sgn, {{16{sgn & lanes[l].cout16[1]}}, lanes[l].cout16[1],
                                  lanes[l].rounded[31:16]}, 8);
    assign clip_w  = f_clip(sgn, {lanes[l].cout32, lanes[l].rounded}, 16);

    assign narrow[l]  = eew16 ? {lanes[l].product[23:16], lanes[l].product[7:0]}
                              : lanes[l].product[15:0];
    assign clipped[l] = eew16 ? {clip_hi[7:0], clip_lo[7:0]} : clip_w[15:0];
    assign sat[l]     = eew16 ? {clip_hi[16], clip_lo[16]} : {1'b0, clip_w[16]};
  end

  always_comb begin
    int base;
    int base_b;
    base      = ctrl.upper_half ? `VLEN/2 : 0;
    base_b    = ctrl.upper_half ? `VLENB/2 : 0;
    w_data    = '0;
    vsaturate = '0;
    for (int l = 0; l < `NUM_LANES; l++) begin
      case (ctrl.mode)
        RES_PLAIN:  w_data[l*`LANE_WIDTH +: `LANE_WIDTH] = lanes[l].product;
        RES_SCALED: w_data[l*`LANE_WIDTH +: `LANE_WIDTH] = lanes[l].rounded;
        RES_NARROW: w_data[base + l*16 +: 16] = narrow[l];
        default: begin
          w_data[base + l*16 +: 16]    = clipped[l];
          // flag sits on the lowest byte of each destination element
          vsaturate[base_b + l*2 +: 2] = sat[l];
        end
      endcase
    end
  end

endmodule

//--- source/vshift_unit.sv
`timescale 1ns/1ps
`include "vshift_defs.svh"

module vshift_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      uop_valid,
  input  vshift_pkg::shift_uop_t    uop,
  output logic                      result_valid,
  output vshift_pkg::shift_result_t result
);
  import vshift_pkg::*;

  logic                              legal;
  shift_ctrl_t                       ctrl;
  logic [`VLEN-1:0]                  operands;
  logic [`VLEN-1:0]                  amounts;
  lane_out_t [`NUM_LANES-1:0]        lanes;
  logic [`VLEN-1:0]                  w_data;
  logic [`VLENB-1:0]                 vsaturate;

  vshift_operand_prep u_prep (
    .uop_valid (uop_valid),
    .uop       (uop),
    .legal     (legal),
    .ctrl      (ctrl),
    .operands  (operands),
    .amounts   (amounts)
  );

  for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
    vshift_lane u_lane (
      .ctrl    (ctrl),
      .operand (operands[l*`LANE_WIDTH +: `LANE_WIDTH]),
      .amount  (amounts[l*`LANE_WIDTH +: `LANE_WIDTH]),
      .lane    (lanes[l])
    );
  end

  vshift_result_pack u_pack (
    .ctrl      (ctrl),
    .lanes     (lanes),
    .w_data    (w_data),
    .vsaturate (vsaturate)
  );

  // single output stage toward the rob
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= legal;
      if (legal) begin
        result.rob_entry <= uop.rob_entry;
        result.w_data    <= w_data;
        result.vsaturate <= vsaturate;
      end
    end
  end

endmodule

//--- tb/tb_vshift_ref.svh
`ifndef TB_VSHIFT_REF_SVH
`define TB_VSHIFT_REF_SVH

// expected data and saturation flags for one uop
function automatic void ref_result(input shift_uop_t u, output logic [127:0] data,
                                   output logic [15:0] sat);
  int          sw;
  int          dw;
  int          base;
  int          pos;
  int          d;
  bit          narrow;
  bit          sgn;
  bit          inc;
  bit          half;
  bit          lower;
  bit          any;
  longint      x;
  longint      sh;
  longint      v;
  longint      lim_hi;
  longint      lim_lo;
  logic [127:0] m;
  sw     = (u.vs2_eew == EEW8) ? 8 : (u.vs2_eew == EEW16) ? 16 : 32;
  narrow = u.funct inside {VNSRL, VNSRA, VNCLIPU, VNCLIP};
  sgn    = u.funct inside {VSRA, VSSRA, VNSRA, VNCLIP};
  dw     = narrow ? sw / 2 : sw;
  base   = (narrow && u.uop_index[0]) ? 64 : 0;
  m      = (128'd1 << dw) - 128'd1;
  data   = '0;
  sat    = '0;
  for (int i = 0; i < 128 / sw; i++) begin
    x = longint'((u.vs2_data >> (sw * i)) & ((128'd1 << sw) - 128'd1));
    if (sgn && x[sw-1])
      x = x - (64'sd1 <<< sw);
    // amount source, then masked to the source element width
    if (u.src != OPIVV)
      d = int'(u.rs1_data[4:0]);
    else if (narrow)
      d = int'((u.vs1_data >> (base + dw * i)) & 128'h1f);
    else
      d = int'((u.vs1_data >> (sw * i)) & 128'h1f);
    d   = d & (sw - 1);
    sh  = x >>> d;
    inc = 1'b0;
    if (d > 0) begin
      half  = ((x >>> (d - 1)) & 64'sd1) != 0;
      lower = (x & ((64'sd1 <<< (d - 1)) - 64'sd1)) != 0;
      any   = (x & ((64'sd1 <<< d) - 64'sd1)) != 0;
      case (u.vxrm)
        RNU:     inc = half;
        RNE:     inc = half && (lower || sh[0]);
        RDN:     inc = 1'b0;
        default: inc = !sh[0] && any;
      endcase
    end
    pos = base + dw * i;
    case (u.funct)
      VSLL:         v = x <<< d;
      VSSRL, VSSRA: v = sh + longint'(inc);
      VNCLIPU, VNCLIP: begin
        v      = sh + longint'(inc);
        lim_hi = sgn ? (64'sd1 <<< (dw - 1)) - 64'sd1 : (64'sd1 <<< dw) - 64'sd1;
        lim_lo = sgn ? -(64'sd1 <<< (dw - 1)) : 64'sd0;
        if (v > lim_hi || v < lim_lo) begin
          v = (v > lim_hi) ? lim_hi : lim_lo;
          sat[pos/8] = 1'b1;
        end
      end
      default:      v = sh;
    endcase
    data = data | ((128'(v) & m) << pos);
  end
endfunction

`endif

//--- tb/tb_vshift_unit.sv
`timescale 1ns/1ps
`include "vshift_defs.svh"

module tb_vshift_unit;
  import vshift_pkg::*;

  `include "tb_vshift_ref.svh"

  typedef struct packed {
    shift_uop_t   uop;
    logic         in_valid;
    logic         exp_valid;
    logic         directed;
    logic [127:0] data;
    logic [15:0]  sat;
  } row_t;

  logic          clk;
  logic          rst_n;
  logic          uop_valid;
  shift_uop_t    uop;
  logic          result_valid;
  shift_result_t result;

  row_t   rows[$];
  integer seed = 32'h6f67_8dd7;
  bit     table_ready = 1'b0;

  vshift_unit u_vshift_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [127:0] rand128();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // valids packs {uop_valid, vs1, vs2, rs1}
  task automatic add_row(input vshift_funct_e f, input operand_src_e s, input vxrm_e rm,
                         input eew_e e, input logic idx, input logic [3:0] valids,
                         input logic exp_v, input logic [127:0] vs1, input logic [127:0] vs2,
                         input logic [31:0] rs1, input logic dir, input logic [127:0] d,
                         input logic [15:0] st);
    row_t r;
    r                    = '0;
    r.uop.rob_entry      = 4'(rows.size());
    r.uop.funct          = f;
    r.uop.src            = s;
    r.uop.vxrm           = rm;
    r.uop.vs2_eew        = e;
    r.uop.uop_index      = {2'b0, idx};
    r.uop.vs1_data       = vs1;
    r.uop.vs2_data       = vs2;
    r.uop.rs1_data       = rs1;
    r.uop.vs1_data_valid = valids[2];
    r.uop.vs2_data_valid = valids[1];
    r.uop.rs1_data_valid = valids[0];
    r.in_valid           = valids[3];
    r.exp_valid          = exp_v;
    r.directed           = dir;
    r.data               = d;
    r.sat                = st;
    rows.push_back(r);
  endtask

  task automatic check_value(input string name, input logic [159:0] exp,
                             input logic [159:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %0h actual %0h", name, exp, act);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_row(input int k);
    row_t         r;
    logic [127:0] ed;
    logic [15:0]  es;
    string        nm;
    r  = rows[k];
    nm = $sformatf("row %0d %s", k, r.uop.funct.name());
    check_value({nm, " valid"}, 160'(r.exp_valid), 160'(result_valid));
    if (r.exp_valid) begin
      if (r.directed) begin
        ed = r.data;
        es = r.sat;
      end else begin
        ref_result(r.uop, ed, es);
      end
      check_value({nm, " rob_entry"}, 160'(r.uop.rob_entry), 160'(result.rob_entry));
      check_value({nm, " w_data"}, 160'(ed), 160'(result.w_data));
      check_value({nm, " vsaturate"}, 160'(es), 160'(result.vsaturate));
    end
  endtask

  task automatic build_table();
    vshift_funct_e plain[3];
    vshift_funct_e scaled[2];
    vshift_funct_e narrow[4];
    eew_e          eews[3];
    plain  = '{VSLL, VSRL, VSRA};
    scaled = '{VSSRL, VSSRA};
    narrow = '{VNSRL, VNSRA, VNCLIPU, VNCLIP};
    eews   = '{EEW8, EEW16, EEW32};
    // directed rows
    add_row(VSRL, OPIVX, RNU, EEW32, 0, 4'hf, 1, '0, {4{32'h8000_0010}}, 32'd4,
            1, {4{32'h0800_0001}}, 16'h0);
    // amount 36 masks down to 4
    add_row(VSRA, OPIVX, RNU, EEW16, 0, 4'hf, 1, '0, {8{16'h8010}}, 32'd36,
            1, {8{16'hf801}}, 16'h0);
    add_row(VSSRL, OPIVI, RNE, EEW8, 0, 4'hf, 1, '0, {16{8'h05}}, 32'd1,
            1, {16{8'h02}}, 16'h0);
    add_row(VNCLIPU, OPIVX, RNU, EEW16, 1, 4'hf, 1, '0, {8{16'h0123}}, 32'd0,
            1, {64'hffff_ffff_ffff_ffff, 64'h0}, 16'hff00);
    for (int f = 0; f < 3; f++)
      for (int e = 0; e < 3; e++)
        for (int s = 0; s < 2; s++)
          add_row(plain[f], s ? OPIVX : OPIVV, RNU, eews[e], 0, 4'hf, 1,
                  rand128(), rand128(), 32'($random(seed)), 0, '0, '0);
    for (int f = 0; f < 2; f++)
      for (int rm = 0; rm < 4; rm++)
        add_row(scaled[f], rm[0] ? OPIVX : OPIVV, vxrm_e'(rm[1:0]), eews[rm % 3], 0,
                4'hf, 1, rand128(), rand128(), 32'($random(seed)), 0, '0, '0);
    for (int f = 0; f < 4; f++)
      for (int e = 1; e < 3; e++)
        for (int idx = 0; idx < 2; idx++)
          add_row(narrow[f], f[0] ? OPIVX : OPIVV, vxrm_e'(e + idx), eews[e], idx[0],
                  4'hf, 1, rand128(), rand128(), 32'($random(seed)), 0, '0, '0);
    // illegal uops
    add_row(VNSRL, OPIVX, RNU, EEW8, 0, 4'hf, 0, rand128(), rand128(), 32'd1, 0, '0, '0);
    add_row(VSLL, OPIVV, RNU, EEW16, 0, 4'b1011, 0, rand128(), rand128(), 32'd1, 0, '0, '0);
    add_row(VSRA, OPIVX, RNU, EEW32, 0, 4'b0111, 0, rand128(), rand128(), 32'd1, 0, '0, '0);
    add_row(VSSRA, OPIVI, RNE, EEW8, 0, 4'b1110, 0, rand128(), rand128(), 32'd1, 0, '0, '0);
    add_row(VNCLIP, OPIVV, ROD, EEW32, 1, 4'hf, 1, rand128(), rand128(), 32'd0, 0, '0, '0);
  endtask

  initial begin
    rst_n     = 1'b0;
    uop_valid = 1'b0;
    uop       = '0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset result_valid", 160'(1'b0), 160'(result_valid));
    check_value("reset result", 160'(0), 160'(result));
    for (int k = 0; k <= rows.size(); k++) begin
      @(posedge clk);
      if (k < rows.size()) begin
        uop_valid <= rows[k].in_valid;
        uop       <= rows[k].uop;
      end else begin
        uop_valid <= 1'b0;
      end
      // output now holds the row issued one edge earlier
      @(negedge clk);
      if (k > 0)
        check_row(k - 1);
    end
    $display("sim passed");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((rows.size() + 40) * 20);
    $display("timeout: the test sequence did not finish in time");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim.f
+incdir+source
+incdir+tb
source/vshift_pkg.sv
source/vshift_operand_prep.sv
source/vshift_lane.sv
source/vshift_result_pack.sv
source/vshift_unit.sv
tb/tb_vshift_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vshift_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_vshift_unit -o vsim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/vsim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
